//--- src/nocPkg.sv
package nocPkg;

  // the arbiter's rotation order is written for exactly five ports.
  localparam int NumPorts = 5;

  typedef logic [31:0] dataT;
  typedef logic [2:0] flitIdT;
  typedef logic [11:0] lengthT;
  typedef logic [2:0] portIdxT;

  localparam flitIdT FlitHead = 3'd1;
  localparam flitIdT FlitBody = 3'd2;

  localparam portIdxT PortL = 3'd0;
  localparam portIdxT PortN = 3'd1;
  localparam portIdxT PortE = 3'd2;
  localparam portIdxT PortW = 3'd3;
  localparam portIdxT PortS = 3'd4;

  // one-hot grant state, where bit p+1 belongs to port index p.
  typedef enum logic [5:0] {
    GrantIdle = 6'b000001,
    GrantL    = 6'b000010,
    GrantN    = 6'b000100,
    GrantE    = 6'b001000,
    GrantW    = 6'b010000,
    GrantS    = 6'b100000
  } grantStateT;

endpackage

//--- src/flitIf.sv
`timescale 1ns/1ns

interface flitIf import nocPkg::*; ();

  // head-of-queue view of one input FIFO.
  logic   req;
  flitIdT flitId;
  dataT   data;
  lengthT length;

  // the head is removed on the edge that samples pop high.
  logic   pop;

  modport src (
    output req,
    output flitId,
    output data,
    output length,
    input  pop
  );

  modport arb (
    input  req,
    input  flitId,
    input  data,
    input  length,
    output pop
  );

endinterface

//--- src/portTimer.sv
`timescale 1ns/1ns

module portTimer import nocPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   headIsHeader,
  input  lengthT length,
  input  logic   run,
  output logic   timesup
);

  lengthT limit;
  lengthT count;

  // a new limit is taken whenever a header sits at the head of the queue.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (headIsHeader)
    begin
      limit <= length;
    end
  end

  // the count restarts in every cycle the port is not holding the grant.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  assign timesup = (count == limit);

endmodule

//--- src/inputPort.sv
`timescale 1ns/1ns

module inputPort import nocPkg::*; #(
  parameter int FifoDepth = 4
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   inValid,
  input  flitIdT inFlitId,
  input  dataT   inData,
  output logic   inReady,
  flitIf.src     q
);

  localparam int AddrW = $clog2(FifoDepth);
  localparam logic [AddrW:0] FullCount = (AddrW + 1)'(FifoDepth);

  flitIdT idMem [FifoDepth];
  dataT dataMem [FifoDepth];

  logic [AddrW-1:0] wrPtr;
  logic [AddrW-1:0] rdPtr;
  logic [AddrW:0] count;
  logic write;
  logic read;
  flitIdT headId;
  dataT headData;
  logic headIsHeader;
  lengthT lenQ;

  assign inReady = (count != FullCount);
  assign write = inValid && inReady;
  assign read = q.pop;

  always_ff @(posedge clk)
  begin
    if (write)
    begin
      idMem[wrPtr] <= inFlitId;
      dataMem[wrPtr] <= inData;
    end
  end

  // pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (write)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (read)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({write, read})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign headId = idMem[rdPtr];
  assign headData = dataMem[rdPtr];
  assign headIsHeader = q.req && (headId == FlitHead);

  // the length of the current packet stays on the interface while its body drains.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lenQ <= '0;
    end
    else if (headIsHeader)
    begin
      lenQ <= headData[$bits(lengthT)-1:0];
    end
  end

  assign q.req = (count != '0);
  assign q.flitId = headId;
  assign q.data = headData;
  assign q.length = headIsHeader ? headData[$bits(lengthT)-1:0] : lenQ;

endmodule

//--- src/outputArbiter.sv
`timescale 1ns/1ns

module outputArbiter import nocPkg::*; (
  input  logic    clk,
  input  logic    rst,
  flitIf.arb      ports [NumPorts],
  output logic    outValid,
  output portIdxT outPort,
  output flitIdT  outFlitId,
  output dataT    outData
);

  grantStateT state;
  grantStateT nextState;
  logic granted;
  portIdxT curPort;

  logic [NumPorts-1:0] req;
  logic [NumPorts-1:0] timesup;
  logic [NumPorts-1:0] run;
  logic [NumPorts-1:0] headIsHeader;
  logic [NumPorts-1:0] pop;
  flitIdT headId [NumPorts];
  dataT headData [NumPorts];
  lengthT headLen [NumPorts];

  // first requesting port when scanning cyclically from index start.
  // the scan runs backwards so that the nearest port is assigned last.
  function automatic portIdxT pickFrom(input int start, input logic [NumPorts-1:0] reqBits);
    int idx;
    portIdxT pick;
    pick = PortL;
    for (int k = NumPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % NumPorts;
      if (reqBits[idx])
      begin
        pick = portIdxT'(idx);
      end
    end
    return pick;
  endfunction

  function automatic grantStateT grantFor(input portIdxT idx);
    return grantStateT'(6'b000010 << idx);
  endfunction

  for (genvar p = 0; p < NumPorts; p++)
  begin : g_port
    assign req[p] = ports[p].req;
    assign headId[p] = ports[p].flitId;
    assign headData[p] = ports[p].data;
    assign headLen[p] = ports[p].length;
    assign headIsHeader[p] = ports[p].req && (ports[p].flitId == FlitHead);
    assign ports[p].pop = pop[p];

    portTimer i_portTimer (
      .clk          (clk),
      .rst          (rst),
      .headIsHeader (headIsHeader[p]),
      .length       (headLen[p]),
      .run          (run[p]),
      .timesup      (timesup[p])
    );
  end

  always_comb
  begin
    granted = 1'b1;
    curPort = PortL;
    case (state)
      GrantL: curPort = PortL;
      GrantN: curPort = PortN;
      GrantE: curPort = PortE;
      GrantW: curPort = PortW;
      GrantS: curPort = PortS;
      default: granted = 1'b0;
    endcase
  end

  // every grant state follows the same rule: hold while the timer allows,
  // otherwise rotate to the next requester after the current port.
  always_comb
  begin
    nextState = GrantIdle;
    run = '0;
    if (!granted)
    begin
      if (|req)
      begin
        nextState = grantFor(pickFrom(int'(PortL), req));
      end
    end
    else if (req[curPort] && !timesup[curPort])
    begin
      run[curPort] = 1'b1;
      nextState = state;
    end
    else if (|req)
    begin
      nextState = grantFor(pickFrom(int'(curPort) + 1, req));
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= GrantIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    pop = '0;
    if (granted)
    begin
      pop[curPort] = req[curPort];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outPort <= curPort;
      outFlitId <= headId[curPort];
      outData <= headData[curPort];
    end
  end

endmodule

//--- src/routerOutputStage.sv
`timescale 1ns/1ns

module routerOutputStage import nocPkg::*; #(
  parameter int FifoDepth = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] inValid,
  input  flitIdT              inFlitId [NumPorts],
  input  dataT                inData [NumPorts],
  output logic [NumPorts-1:0] inReady,
  output logic                outValid,
  output portIdxT             outPort,
  output flitIdT              outFlitId,
  output dataT                outData
);

  // one head-of-queue link per input port, indexed L, N, E, W, S.
  flitIf portIfs [NumPorts] ();

  for (genvar p = 0; p < NumPorts; p++)
  begin : g_input
    inputPort #(
      .FifoDepth (FifoDepth)
    ) i_inputPort (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[p]),
      .inFlitId (inFlitId[p]),
      .inData   (inData[p]),
      .inReady  (inReady[p]),
      .q        (portIfs[p])
    );
  end

  outputArbiter i_outputArbiter (
    .clk       (clk),
    .rst       (rst),
    .ports     (portIfs),
    .outValid  (outValid),
    .outPort   (outPort),
    .outFlitId (outFlitId),
    .outData   (outData)
  );

endmodule

//--- tests/routerOutputAsserts.sv
`timescale 1ns/1ns

module routerOutputAsserts import nocPkg::*; (
  input logic                clk,
  input logic                rst,
  input logic [NumPorts-1:0] inValid,
  input logic [NumPorts-1:0] inReady,
  input logic                outValid,
  input flitIdT              outFlitId
);

  // the output stays quiet during reset and in the first cycle after it.
  property quietAfterReset;
    @(posedge clk) rst |=> !outValid;
  endproperty

  // a source offers a flit only while its FIFO has room.
  property noWriteWhenFull;
    @(posedge clk) disable iff (rst) (inValid & ~inReady) == '0;
  endproperty

  property knownFlitKind;
    @(posedge clk) disable iff (rst)
      outValid |-> (outFlitId == FlitHead || outFlitId == FlitBody);
  endproperty

  assert property (quietAfterReset)
    else $error("outValid was high during or right after reset");

  assert property (noWriteWhenFull)
    else $error("a flit was offered to a full input FIFO");

  assert property (knownFlitKind)
    else $error("outFlitId is neither a header nor a body flit");

endmodule

bind routerOutputStage routerOutputAsserts i_routerOutputAsserts (.*);

//--- tests/tbRouterOutput.sv
`timescale 1ns/1ns

module tbRouterOutput import nocPkg::*; ();

  localparam int FifoDepth = 4;
  localparam int PacketsPerPort = 6;

  logic clk;
  logic rst;
  logic [NumPorts-1:0] inValid;
  flitIdT inFlitId [NumPorts];
  dataT inData [NumPorts];
  logic [NumPorts-1:0] inReady;
  logic outValid;
  portIdxT outPort;
  flitIdT outFlitId;
  dataT outData;

  // queue entries are {flit id, data}; an id of zero in sendQ marks an idle cycle.
  logic [34:0] sendQ [NumPorts][$];
  logic [34:0] modelQ [NumPorts][$];
  lengthT lenLatest [NumPorts];

  logic [31:0] seed = 32'd81;
  int errors = 0;
  int timeouts = 0;
  int cycles = 0;
  int totalFlits = 0;
  int cycleLimit = 0;
  int firstWrite = -1;
  int runCount = 0;
  logic firstOutSeen = 1'b0;
  logic lastValid = 1'b0;
  portIdxT lastPort = PortL;
  logic [NumPorts-1:0] hold1 = '0;
  logic [NumPorts-1:0] hold2 = '0;

  routerOutputStage #(
    .FifoDepth (FifoDepth)
  ) i_routerOutputStage (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlitId  (inFlitId),
    .inData    (inData),
    .inReady   (inReady),
    .outValid  (outValid),
    .outPort   (outPort),
    .outFlitId (outFlitId),
    .outData   (outData)
  );

  function automatic logic [15:0] nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[31:16];
  endfunction

  task automatic reportValue(input string name, input logic [31:0] expVal,
                             input logic [31:0] actVal);
    errors++;
    $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expVal, actVal);
  endtask

  task automatic reportProblem(input string msg);
    errors++;
    $display("Problem at %0t ns: %s", $time, msg);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    int len;
    int gap;
    rst = 1'b1;
    inValid = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      inFlitId[p] = '0;
      inData[p] = '0;
      lenLatest[p] = '0;
      // the first packet has no gap, so all five headers go in together.
      for (int k = 0; k < PacketsPerPort; k++)
      begin
        gap = (k == 0) ? 0 : nextRand() % 4;
        len = 1 + nextRand() % 5;
        for (int g = 0; g < gap; g++)
        begin
          sendQ[p].push_back(35'd0);
        end
        sendQ[p].push_back({FlitHead, nextRand(), 4'(p), 12'(len)});
        for (int b = 0; b < len; b++)
        begin
          sendQ[p].push_back({FlitBody, nextRand(), nextRand()});
        end
        totalFlits += len + 1;
      end
    end
    cycleLimit = 20 * totalFlits + 200;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

  always @(posedge clk)
  begin
    logic [34:0] expFlit;
    logic [NumPorts-1:0] holdNow;
    logic [NumPorts-1:0] others;
    int expPort;
    int occ;
    logic done;
    if (rst)
    begin
      inValid <= '0;
    end
    else
    begin
      cycles++;
      if (outValid)
      begin
        if (modelQ[outPort].size() == 0)
        begin
          reportProblem($sformatf("port %0d sent a flit that was never written", outPort));
        end
        else
        begin
          expFlit = modelQ[outPort].pop_front();
          assert (outFlitId == expFlit[34:32])
            else reportValue("outFlitId", 32'(expFlit[34:32]), 32'(outFlitId));
          assert (outData == expFlit[31:0])
            else reportValue("outData", expFlit[31:0], outData);
        end
        if (!firstOutSeen)
        begin
          firstOutSeen = 1'b1;
          assert (outPort == PortL) else reportValue("outPort", 32'(PortL), 32'(outPort));
          assert (cycles == firstWrite + 3)
            else reportValue("first outValid cycle", 32'(firstWrite + 3), 32'(cycles));
        end
        // a new port must be the next holder after the old one, seen when the grant moved.
        if (lastValid && outPort != lastPort)
        begin
          expPort = int'(lastPort);
          for (int k = NumPorts; k >= 1; k--)
          begin
            if (hold2[(int'(lastPort) + k) % NumPorts])
            begin
              expPort = (int'(lastPort) + k) % NumPorts;
            end
          end
          assert (int'(outPort) == expPort) else reportValue("outPort", expPort, outPort);
        end
        if (outFlitId == FlitHead)
        begin
          lenLatest[outPort] = outData[11:0];
        end
        others = hold1 & ~(NumPorts'(1) << outPort);
        if (lastValid && outPort == lastPort)
        begin
          runCount = (others != '0) ? runCount + 1 : 0;
        end
        else
        begin
          runCount = (others != '0) ? 1 : 0;
        end
        assert (runCount <= int'(lenLatest[outPort]) + 1)
          else reportValue("consecutive flits", int'(lenLatest[outPort]) + 1, runCount);
      end
      lastValid = outValid;
      lastPort = outPort;

      done = 1'b1;
      for (int p = 0; p < NumPorts; p++)
      begin
        occ = modelQ[p].size();
        holdNow[p] = (occ != 0);
        assert (inReady[p] == (occ != FifoDepth))
          else reportValue($sformatf("inReady[%0d]", p), occ != FifoDepth, inReady[p]);
        if (inValid[p] && inReady[p])
        begin
          modelQ[p].push_back(sendQ[p].pop_front());
          if (firstWrite < 0)
          begin
            firstWrite = cycles;
          end
        end
        if (sendQ[p].size() != 0 && sendQ[p][0][34:32] == 3'd0)
        begin
          void'(sendQ[p].pop_front());
          inValid[p] <= 1'b0;
        end
        else if (sendQ[p].size() != 0 && modelQ[p].size() < FifoDepth)
        begin
          inValid[p] <= 1'b1;
          inFlitId[p] <= sendQ[p][0][34:32];
          inData[p] <= sendQ[p][0][31:0];
        end
        else
        begin
          inValid[p] <= 1'b0;
        end
        if (sendQ[p].size() != 0 || modelQ[p].size() != 0)
        begin
          done = 1'b0;
        end
      end
      hold2 = hold1;
      hold1 = holdNow;

      if (done || cycles > cycleLimit)
      begin
        if (!done)
        begin
          timeouts++;
          $display("Run stopped after %0d cycles with flits still undelivered", cycles);
        end
        $display("Closing report: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
          $display("Test completed successfully");
        end
        else
        begin
          $display("Test failed");
        end
        $finish;
      end
    end
  end

endmodule

//--- sim.f
src/nocPkg.sv
src/flitIf.sv
src/portTimer.sv
src/inputPort.sv
src/outputArbiter.sv
src/routerOutputStage.sv
tests/routerOutputAsserts.sv
tests/tbRouterOutput.sv

//--- run.sh
#!/bin/bash
# builds the testbench with Verilator, runs it and checks the log for the pass message.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tbRouterOutput \
  -o simv > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "^Test completed successfully$" sim.log && exit 0 || exit 1
